// ==== list.f ====
cam_pkg.sv
cam_reg_block.sv
cam_pixel_fifo.sv
cam_format_packer.sv
cam_capture_top.sv
tb_cam_capture.sv

// ==== Bender.yml ====
package:
  name: cam_capture

sources:
  - files:
      - cam_pkg.sv
      - cam_reg_block.sv
      - cam_pixel_fifo.sv
      - cam_format_packer.sv
      - cam_capture_top.sv
  - target: test
    files:
      - tb_cam_capture.sv

// ==== tb_cam_capture.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cam_capture;

    import cam_pkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 5;
    localparam int LINES           = 3;
    localparam int PIX_PER_LINE    = 8;
    localparam int FRAME_BEATS     = LINES * PIX_PER_LINE;
    localparam int FRAMES_PER_FMT  = 2;
    localparam int NUM_FMTS        = 6;
    localparam int IDLE_CHECK      = 8;
    // Six formats, the short flushed frame and one frame after the flush
    localparam int TOTAL_BEATS     = NUM_FMTS * FRAMES_PER_FMT * FRAME_BEATS
                                     + PIX_PER_LINE + FRAME_BEATS;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20 + 500;

    logic                      axi4s_cam_aclk;
    logic                      sys_reset;

    axil_wr_t                  axil_wr;
    logic                      awvalid;
    logic                      wvalid;
    logic                      bready;
    logic                      awready;
    logic                      wready;
    logic                      bvalid;
    logic [AXIL_ADDR_BITS-1:0] araddr;
    logic                      arvalid;
    logic                      rready;
    logic                      arready;
    logic                      rvalid;
    logic [AXIL_DATA_BITS-1:0] rdata;
    logic                      cam_enable;

    rgb_beat_t                 s_beat;
    logic                      s_valid;
    logic                      s_ready;
    out_beat_t                 m_beat;
    logic                      m_valid;
    logic                      m_ready = 1'b0;

    integer                    seed       = 17;
    integer                    ready_seed = 17;
    logic                      ready_rand  = 1'b0;
    logic                      flushing    = 1'b0;

    // Reference model
    out_beat_t                 ref_q[$];
    int                        ref_count   = 0;
    out_beat_t                 exp_head    = '0;
    fmt_sel_e                  fmt_model   = FMT_BGRX8;
    logic [7:0]                frame_model = '0;

    cam_capture_top dut_i (
        .axi4s_cam_aclk (axi4s_cam_aclk),
        .sys_reset      (sys_reset),
        .axil_wr_i      (axil_wr),
        .awvalid_i      (awvalid),
        .wvalid_i       (wvalid),
        .bready_i       (bready),
        .awready_o      (awready),
        .wready_o       (wready),
        .bvalid_o       (bvalid),
        .araddr_i       (araddr),
        .arvalid_i      (arvalid),
        .rready_i       (rready),
        .arready_o      (arready),
        .rvalid_o       (rvalid),
        .rdata_o        (rdata),
        .cam_enable_o   (cam_enable),
        .s_beat_i       (s_beat),
        .s_valid_i      (s_valid),
        .s_ready_o      (s_ready),
        .m_beat_o       (m_beat),
        .m_valid_o      (m_valid),
        .m_ready_i      (m_ready)
    );

    initial begin
        axi4s_cam_aclk = 1'b0;
        forever #(CLK_PERIOD / 2) axi4s_cam_aclk = ~axi4s_cam_aclk;
    end

    // --------------------------------------------------
    //  Helpers
    // --------------------------------------------------

    task automatic fail_now(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        $display("Testbench failed");
        $fatal(1, "first error seen");
    endtask

    function automatic logic [AXIL_ADDR_BITS-1:0] reg_addr(input logic [2:0] idx);
        return AXIL_ADDR_BITS'(idx) << REG_IDX_LSB;
    endfunction

    // Memory word layouts, MSB first
    function automatic out_beat_t pack_expected(input rgb_beat_t beat, input fmt_sel_e fmt);
        out_beat_t o;
        pix_rgb_t  px;
        px      = beat.data;
        o.tuser = beat.tuser;
        o.tlast = beat.tlast;
        case (fmt)
            FMT_BGRX8: o.tdata = {px.raw[9:2], px.r[9:2], px.g[9:2], px.b[9:2]};
            FMT_RGBX8: o.tdata = {px.raw[9:2], px.b[9:2], px.g[9:2], px.r[9:2]};
            FMT_RAW10: o.tdata = {22'd0, px.raw};
            FMT_RAW16: o.tdata = {16'd0, px.raw, px.raw[9:4]};
            FMT_BGR10: o.tdata = {2'd0, px.r, px.g, px.b};
            FMT_RGB10: o.tdata = {2'd0, px.b, px.g, px.r};
            default:   o.tdata = '0;
        endcase
        return o;
    endfunction

    task automatic reg_write(input logic [AXIL_ADDR_BITS-1:0] addr,
                             input logic [AXIL_DATA_BITS-1:0] data,
                             input logic [AXIL_STRB_BITS-1:0] strb);
        axil_wr_t req;
        req.awaddr = addr;
        req.wdata  = data;
        req.wstrb  = strb;
        @(posedge axi4s_cam_aclk);
        axil_wr <= req;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        @(posedge axi4s_cam_aclk);
        while (!(awready && wready)) @(posedge axi4s_cam_aclk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(posedge axi4s_cam_aclk);
        while (!bvalid) @(posedge axi4s_cam_aclk);
        bready <= 1'b0;
    endtask

    task automatic reg_read(input logic [AXIL_ADDR_BITS-1:0] addr,
                            output logic [AXIL_DATA_BITS-1:0] data);
        @(posedge axi4s_cam_aclk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        @(posedge axi4s_cam_aclk);
        while (!arready) @(posedge axi4s_cam_aclk);
        arvalid <= 1'b0;
        @(posedge axi4s_cam_aclk);
        while (!rvalid) @(posedge axi4s_cam_aclk);
        data   = rdata;          // Value before the edge that takes it
        rready <= 1'b0;
    endtask

    task automatic expect_reg(input logic [AXIL_ADDR_BITS-1:0] addr,
                              input logic [AXIL_DATA_BITS-1:0] expected,
                              input string what);
        logic [AXIL_DATA_BITS-1:0] got;
        reg_read(addr, got);
        assert (got === expected)
            else fail_now($sformatf("%s read 0x%08h, expected 0x%08h", what, got, expected));
    endtask

    task automatic send_frame(input int lines, input int pix_per_line);
        rgb_beat_t   beat;
        logic [63:0] bits;
        int          l;
        int          p;
        @(posedge axi4s_cam_aclk);
        for (l = 0; l < lines; l++) begin
            for (p = 0; p < pix_per_line; p++) begin
                if (($random(seed) & 7) == 0) begin    // Occasional gap in valid
                    s_valid <= 1'b0;
                    @(posedge axi4s_cam_aclk);
                end
                bits       = {$random(seed), $random(seed)};
                beat.tuser = (l == 0) && (p == 0);
                beat.tlast = (p == pix_per_line - 1);
                beat.data  = bits[39:0];
                s_beat  <= beat;
                s_valid <= 1'b1;
                @(posedge axi4s_cam_aclk);
                while (!s_ready) @(posedge axi4s_cam_aclk);
            end
        end
        s_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        @(negedge axi4s_cam_aclk);
        while (ref_count != 0) @(negedge axi4s_cam_aclk);
    endtask

    // --------------------------------------------------
    //  Output ready and reference model
    // --------------------------------------------------

    always @(posedge axi4s_cam_aclk) begin
        if (ready_rand) begin
            m_ready <= ($random(ready_seed) & 1) != 0;
        end else begin
            m_ready <= 1'b0;
        end
    end

    always @(posedge axi4s_cam_aclk) begin
        if (!sys_reset) begin
            if (m_valid && m_ready && ref_q.size() > 0) begin
                void'(ref_q.pop_front());
            end
            if (s_valid && s_ready) begin
                ref_q.push_back(pack_expected(s_beat, fmt_model));
            end
            if (s_valid && s_beat.tuser) begin
                frame_model = frame_model + 1'b1;    // Every cycle with a frame start
            end
        end
        ref_count = ref_q.size();
        if (ref_q.size() > 0) begin
            exp_head = ref_q[0];
        end else begin
            exp_head = '0;
        end
    end

    // --------------------------------------------------
    //  Assertions
    // --------------------------------------------------

    reset_idle: assert property (@(posedge axi4s_cam_aclk)
        sys_reset |=> (!m_valid && !bvalid && !rvalid && !cam_enable))
        else fail_now("outputs not idle after reset");

    no_extra_beat: assert property (@(posedge axi4s_cam_aclk) disable iff (sys_reset)
        (m_valid && m_ready) |-> (ref_count > 0))
        else fail_now("output beat with no matching input beat");

    beat_matches: assert property (@(posedge axi4s_cam_aclk) disable iff (sys_reset)
        (m_valid && m_ready && ref_count > 0) |-> (m_beat == exp_head))
        else fail_now($sformatf("output beat 0x%09h, expected 0x%09h",
                                $sampled(m_beat), $sampled(exp_head)));

    hold_when_stalled: assert property (@(posedge axi4s_cam_aclk)
        disable iff (sys_reset || flushing)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_beat)))
        else fail_now("output beat changed or dropped while stalled");

    // --------------------------------------------------
    //  Test sequence
    // --------------------------------------------------

    initial begin : main
        int fmt_i;
        sys_reset = 1'b1;
        axil_wr   = '0;
        awvalid   = 1'b0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        s_beat    = '0;
        s_valid   = 1'b0;
        repeat (RESET_CYCLES) @(posedge axi4s_cam_aclk);
        sys_reset <= 1'b0;

        expect_reg(reg_addr(REG_ID), REG_ID_VALUE, "ID register");
        expect_reg(reg_addr(3'd7), '0, "unmapped index");

        reg_write(reg_addr(REG_CAM_ENABLE), 32'h1, 4'hf);
        expect_reg(reg_addr(REG_CAM_ENABLE), 32'h1, "camera enable");
        @(negedge axi4s_cam_aclk);
        assert (cam_enable === 1'b1) else fail_now("cam_enable_o does not follow register");
        reg_write(reg_addr(REG_CAM_ENABLE), 32'h0, 4'he);   // Byte 0 masked off
        expect_reg(reg_addr(REG_CAM_ENABLE), 32'h1, "camera enable after masked write");
        reg_write(reg_addr(REG_FMT_SELECT), 32'h5, 4'h1);
        expect_reg(reg_addr(REG_FMT_SELECT), 32'h5, "format select");

        // All formats under random back-pressure
        ready_rand <= 1'b1;
        for (fmt_i = 0; fmt_i < NUM_FMTS; fmt_i++) begin
            reg_write(reg_addr(REG_FMT_SELECT), 32'(fmt_i), 4'h1);
            fmt_model = fmt_sel_e'(fmt_i);
            repeat (FRAMES_PER_FMT) send_frame(LINES, PIX_PER_LINE);
            wait_drain();
        end
        expect_reg(reg_addr(REG_FRAME_COUNT), 32'(frame_model), "frame count");

        // Soft reset with beats stuck in the pipeline
        ready_rand  <= 1'b0;
        send_frame(1, PIX_PER_LINE);
        @(negedge axi4s_cam_aclk);
        while (!m_valid) @(negedge axi4s_cam_aclk);
        flushing <= 1'b1;
        reg_write(reg_addr(REG_SW_RESET), 32'h1, 4'h1);
        @(negedge axi4s_cam_aclk);
        ref_q.delete();
        frame_model = '0;
        reg_write(reg_addr(REG_SW_RESET), 32'h0, 4'h1);
        repeat (IDLE_CHECK) begin
            @(negedge axi4s_cam_aclk);
            assert (!m_valid) else fail_now("m_valid_o high after soft reset with no input");
        end
        flushing <= 1'b0;
        expect_reg(reg_addr(REG_FRAME_COUNT), '0, "frame count after soft reset");

        ready_rand <= 1'b1;
        send_frame(LINES, PIX_PER_LINE);
        wait_drain();
        expect_reg(reg_addr(REG_FRAME_COUNT), 32'(frame_model), "frame count after restart");

        $display("Testbench passed");
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge axi4s_cam_aclk);
        $display("Timeout: the run was still busy after %0d clock cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== cam_capture_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cam_capture_top (
    input  var logic                               axi4s_cam_aclk,
    input  var logic                               sys_reset,

    // Register bus
    input  var cam_pkg::axil_wr_t                  axil_wr_i,
    input  var logic                               awvalid_i,
    input  var logic                               wvalid_i,
    input  var logic                               bready_i,
    output logic                                   awready_o,
    output logic                                   wready_o,
    output logic                                   bvalid_o,
    input  var logic [cam_pkg::AXIL_ADDR_BITS-1:0] araddr_i,
    input  var logic                               arvalid_i,
    input  var logic                               rready_i,
    output logic                                   arready_o,
    output logic                                   rvalid_o,
    output logic     [cam_pkg::AXIL_DATA_BITS-1:0] rdata_o,

    output logic                                   cam_enable_o,

    // Pixel stream in
    input  var cam_pkg::rgb_beat_t                 s_beat_i,
    input  var logic                               s_valid_i,
    output logic                                   s_ready_o,

    // Packed stream out
    output cam_pkg::out_beat_t                     m_beat_o,
    output logic                                   m_valid_o,
    input  var logic                               m_ready_i
);

    import cam_pkg::*;

    logic      sw_reset;
    fmt_sel_e  fmt_sel;

    rgb_beat_t fifo_beat;
    logic      fifo_valid;
    logic      fifo_ready;

    // --------------------------------------------------
    //  Control registers
    // --------------------------------------------------

    cam_reg_block u_reg_block (
        .axi4s_cam_aclk (axi4s_cam_aclk),
        .sys_reset      (sys_reset),
        .axil_wr_i      (axil_wr_i),
        .awvalid_i      (awvalid_i),
        .wvalid_i       (wvalid_i),
        .bready_i       (bready_i),
        .awready_o      (awready_o),
        .wready_o       (wready_o),
        .bvalid_o       (bvalid_o),
        .araddr_i       (araddr_i),
        .arvalid_i      (arvalid_i),
        .rready_i       (rready_i),
        .arready_o      (arready_o),
        .rvalid_o       (rvalid_o),
        .rdata_o        (rdata_o),
        .frame_beat_i   (s_beat_i),     // Frame starts counted at the input
        .frame_valid_i  (s_valid_i),
        .sw_reset_o     (sw_reset),
        .cam_enable_o   (cam_enable_o),
        .fmt_sel_o      (fmt_sel)
    );

    // --------------------------------------------------
    //  Datapath
    // --------------------------------------------------

    cam_pixel_fifo u_pixel_fifo (
        .axi4s_cam_aclk (axi4s_cam_aclk),
        .sys_reset      (sys_reset),
        .flush_i        (sw_reset),
        .s_beat_i       (s_beat_i),
        .s_valid_i      (s_valid_i),
        .s_ready_o      (s_ready_o),
        .m_beat_o       (fifo_beat),
        .m_valid_o      (fifo_valid),
        .m_ready_i      (fifo_ready)
    );

    cam_format_packer u_format_packer (
        .fmt_sel_i      (fmt_sel),
        .s_beat_i       (fifo_beat),
        .s_valid_i      (fifo_valid),
        .s_ready_o      (fifo_ready),
        .m_beat_o       (m_beat_o),
        .m_valid_o      (m_valid_o),
        .m_ready_i      (m_ready_i)
    );

endmodule

`default_nettype wire

// ==== cam_format_packer.sv ====
`timescale 1ns/10ps
`default_nettype none

module cam_format_packer (
    input  var cam_pkg::fmt_sel_e  fmt_sel_i,

    input  var cam_pkg::rgb_beat_t s_beat_i,
    input  var logic               s_valid_i,
    output logic                   s_ready_o,

    output cam_pkg::out_beat_t     m_beat_o,
    output logic                   m_valid_o,
    input  var logic               m_ready_i
);

    import cam_pkg::*;

    pix_rgb_t            pix;
    logic [OUT_BITS-1:0] word;

    assign pix = s_beat_i.data;

    // --------------------------------------------------
    //  Word layout per format
    // --------------------------------------------------

    always_comb begin
        word = '0;
        case (fmt_sel_i)
            FMT_BGRX8: begin
                word[ 7: 0] = pix.b[PIX_BITS-1 -: 8];     // Top 8 bits only
                word[15: 8] = pix.g[PIX_BITS-1 -: 8];
                word[23:16] = pix.r[PIX_BITS-1 -: 8];
                word[31:24] = pix.raw[PIX_BITS-1 -: 8];
            end
            FMT_RGBX8: begin
                word[ 7: 0] = pix.r[PIX_BITS-1 -: 8];
                word[15: 8] = pix.g[PIX_BITS-1 -: 8];
                word[23:16] = pix.b[PIX_BITS-1 -: 8];
                word[31:24] = pix.raw[PIX_BITS-1 -: 8];
            end
            FMT_RAW10: begin
                word[PIX_BITS-1:0] = pix.raw;
            end
            FMT_RAW16: begin
                // Replicate the MSBs to fill 16 bits
                word[15:0] = {pix.raw, pix.raw[PIX_BITS-1 -: 6]};
            end
            FMT_BGR10: begin
                word[0*PIX_BITS +: PIX_BITS] = pix.b;
                word[1*PIX_BITS +: PIX_BITS] = pix.g;
                word[2*PIX_BITS +: PIX_BITS] = pix.r;
            end
            FMT_RGB10: begin
                word[0*PIX_BITS +: PIX_BITS] = pix.r;
                word[1*PIX_BITS +: PIX_BITS] = pix.g;
                word[2*PIX_BITS +: PIX_BITS] = pix.b;
            end
            default: ;                                      // Unknown select gives zero
        endcase
    end

    // --------------------------------------------------
    //  Stream pass-through
    // --------------------------------------------------

    always_comb begin
        m_beat_o.tuser = s_beat_i.tuser;
        m_beat_o.tlast = s_beat_i.tlast;
        m_beat_o.tdata = word;
    end

    assign m_valid_o = s_valid_i;
    assign s_ready_o = m_ready_i;   // No storage here

endmodule

`default_nettype wire

// ==== cam_pixel_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module cam_pixel_fifo (
    input  var logic               axi4s_cam_aclk,
    input  var logic               sys_reset,
    input  var logic               flush_i,

    input  var cam_pkg::rgb_beat_t s_beat_i,
    input  var logic               s_valid_i,
    output logic                   s_ready_o,

    output cam_pkg::rgb_beat_t     m_beat_o,
    output logic                   m_valid_o,
    input  var logic               m_ready_i
);

    import cam_pkg::*;

    rgb_beat_t                mem [FIFO_DEPTH];

    // One extra bit separates full from empty
    logic [FIFO_PTR_BITS:0]   wr_ptr_q;
    logic [FIFO_PTR_BITS:0]   rd_ptr_q;
    logic [FIFO_PTR_BITS:0]   mem_used;
    logic [FIFO_PTR_BITS+1:0] level;

    rgb_beat_t                out_beat_q;
    logic                     out_valid_q;

    logic                     push;
    logic                     load;

    assign mem_used = wr_ptr_q - rd_ptr_q;
    assign level    = {1'b0, mem_used} + (FIFO_PTR_BITS+2)'(out_valid_q);   // Incl. output stage

    assign s_ready_o = !flush_i && (level < (FIFO_PTR_BITS+2)'(FIFO_DEPTH));
    assign push      = s_valid_i && s_ready_o;

    // Refill the output stage when it is empty or being drained
    assign load = (mem_used != '0) && (!out_valid_q || m_ready_i);

    // --------------------------------------------------
    //  Storage
    // --------------------------------------------------

    always_ff @(posedge axi4s_cam_aclk) begin
        if (push) begin
            mem[wr_ptr_q[FIFO_PTR_BITS-1:0]] <= s_beat_i;
        end
    end

    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (load) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    //  Output stage
    // --------------------------------------------------

    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset || flush_i) begin
            out_valid_q <= 1'b0;
        end else if (load) begin
            out_valid_q <= 1'b1;
        end else if (m_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge axi4s_cam_aclk) begin
        if (load) begin
            out_beat_q <= mem[rd_ptr_q[FIFO_PTR_BITS-1:0]];
        end
    end

    assign m_beat_o  = out_beat_q;
    assign m_valid_o = out_valid_q && !flush_i;   // Empty for the whole flush

endmodule

`default_nettype wire

// ==== cam_reg_block.sv ====
`timescale 1ns/10ps
`default_nettype none

module cam_reg_block (
    input  var logic                               axi4s_cam_aclk,
    input  var logic                               sys_reset,

    input  var cam_pkg::axil_wr_t                  axil_wr_i,
    input  var logic                               awvalid_i,
    input  var logic                               wvalid_i,
    input  var logic                               bready_i,
    output logic                                   awready_o,
    output logic                                   wready_o,
    output logic                                   bvalid_o,

    input  var logic [cam_pkg::AXIL_ADDR_BITS-1:0] araddr_i,
    input  var logic                               arvalid_i,
    input  var logic                               rready_i,
    output logic                                   arready_o,
    output logic                                   rvalid_o,
    output logic     [cam_pkg::AXIL_DATA_BITS-1:0] rdata_o,

    input  var cam_pkg::rgb_beat_t                 frame_beat_i,
    input  var logic                               frame_valid_i,

    output logic                                   sw_reset_o,
    output logic                                   cam_enable_o,
    output cam_pkg::fmt_sel_e                      fmt_sel_o
);

    import cam_pkg::*;

    reg_idx_e                  wr_idx;
    reg_idx_e                  rd_idx;
    logic                      wr_fire;
    logic                      rd_fire;

    logic                      bvalid_q;
    logic                      rvalid_q;
    logic [AXIL_DATA_BITS-1:0] rdata_q;

    logic                      sw_reset_q;
    logic                      cam_enable_q;
    fmt_sel_e                  fmt_sel_q;
    logic [FRAME_CNT_BITS-1:0] frame_cnt_q;

    // Register index straight from the address, no decoder in front
    assign wr_idx = reg_idx_e'(axil_wr_i.awaddr[REG_IDX_LSB +: REG_IDX_BITS]);
    assign rd_idx = reg_idx_e'(araddr_i[REG_IDX_LSB +: REG_IDX_BITS]);

    // --------------------------------------------------
    //  Write channel
    // --------------------------------------------------

    assign awready_o = wvalid_i  && !bvalid_q;
    assign wready_o  = awvalid_i && !bvalid_q;
    assign wr_fire   = awvalid_i && wvalid_i && !bvalid_q;

    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset) begin
            bvalid_q     <= 1'b0;
            sw_reset_q   <= 1'b0;
            cam_enable_q <= 1'b0;
            fmt_sel_q    <= FMT_BGRX8;
        end else begin
            if (bready_i) begin
                bvalid_q <= 1'b0;
            end
            if (wr_fire) begin
                bvalid_q <= 1'b1;      // Unmapped index still gets a response
                if (axil_wr_i.wstrb[0]) begin
                    case (wr_idx)
                        REG_SW_RESET:   sw_reset_q   <= axil_wr_i.wdata[0];
                        REG_CAM_ENABLE: cam_enable_q <= axil_wr_i.wdata[0];
                        REG_FMT_SELECT: fmt_sel_q    <= fmt_sel_e'(axil_wr_i.wdata[2:0]);
                        default: ;
                    endcase
                end
            end
        end
    end

    assign bvalid_o = bvalid_q;

    // --------------------------------------------------
    //  Read channel
    // --------------------------------------------------

    assign arready_o = !rvalid_q;
    assign rd_fire   = arvalid_i && !rvalid_q;

    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset) begin
            rvalid_q <= 1'b0;
        end else if (rd_fire) begin
            rvalid_q <= 1'b1;
        end else if (rready_i) begin
            rvalid_q <= 1'b0;
        end
    end

    // Held while rvalid waits for rready
    always_ff @(posedge axi4s_cam_aclk) begin
        if (rd_fire) begin
            case (rd_idx)
                REG_ID:          rdata_q <= REG_ID_VALUE;
                REG_SW_RESET:    rdata_q <= AXIL_DATA_BITS'(sw_reset_q);
                REG_CAM_ENABLE:  rdata_q <= AXIL_DATA_BITS'(cam_enable_q);
                REG_FMT_SELECT:  rdata_q <= AXIL_DATA_BITS'(fmt_sel_q);
                REG_FRAME_COUNT: rdata_q <= AXIL_DATA_BITS'(frame_cnt_q);
                default:         rdata_q <= '0;
            endcase
        end
    end

    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;

    // --------------------------------------------------
    //  Frame counter
    // --------------------------------------------------

    // Counts frame starts seen on the input, wraps at 255
    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset || sw_reset_q) begin
            frame_cnt_q <= '0;
        end else if (frame_valid_i && frame_beat_i.tuser) begin
            frame_cnt_q <= frame_cnt_q + 1'b1;
        end
    end

    assign sw_reset_o   = sw_reset_q;
    assign cam_enable_o = cam_enable_q;
    assign fmt_sel_o    = fmt_sel_q;

endmodule

`default_nettype wire

// ==== cam_pkg.sv ====
`default_nettype none

package cam_pkg;

    // --------------------------------------------------
    //  Widths
    // --------------------------------------------------

    localparam int PIX_BITS       = 10;                 // One raw or color component
    localparam int OUT_BITS       = 32;                 // Packed memory word
    localparam int AXIL_ADDR_BITS = 16;
    localparam int AXIL_DATA_BITS = 32;
    localparam int AXIL_STRB_BITS = AXIL_DATA_BITS / 8;

    // Register map, 8-byte spacing
    localparam int REG_IDX_LSB    = 3;
    localparam int REG_IDX_BITS   = 3;
    localparam logic [AXIL_DATA_BITS-1:0] REG_ID_VALUE = 32'h0123_4567;

    localparam int FRAME_CNT_BITS = 8;

    // Pixel FIFO
    localparam int FIFO_PTR_BITS  = 4;
    localparam int FIFO_DEPTH     = 1 << FIFO_PTR_BITS;

    // --------------------------------------------------
    //  Encodings
    // --------------------------------------------------

    typedef enum logic [REG_IDX_BITS-1:0] {
        REG_ID          = 3'd0,   // Read only
        REG_SW_RESET    = 3'd1,
        REG_CAM_ENABLE  = 3'd2,
        REG_FMT_SELECT  = 3'd3,
        REG_FRAME_COUNT = 3'd4    // Read only
    } reg_idx_e;

    typedef enum logic [2:0] {
        FMT_BGRX8 = 3'd0,
        FMT_RGBX8 = 3'd1,
        FMT_RAW10 = 3'd2,
        FMT_RAW16 = 3'd3,
        FMT_BGR10 = 3'd4,
        FMT_RGB10 = 3'd5
    } fmt_sel_e;

    // --------------------------------------------------
    //  Stream and bus bundles
    // --------------------------------------------------

    // Demosaiced pixel, raw on top
    typedef struct packed {
        logic [PIX_BITS-1:0] raw;
        logic [PIX_BITS-1:0] r;
        logic [PIX_BITS-1:0] g;
        logic [PIX_BITS-1:0] b;
    } pix_rgb_t;

    typedef struct packed {
        logic     tuser;          // Frame start
        logic     tlast;          // Line end
        pix_rgb_t data;
    } rgb_beat_t;

    typedef struct packed {
        logic                tuser;
        logic                tlast;
        logic [OUT_BITS-1:0] tdata;
    } out_beat_t;

    // Write address and data travel together
    typedef struct packed {
        logic [AXIL_ADDR_BITS-1:0] awaddr;
        logic [AXIL_DATA_BITS-1:0] wdata;
        logic [AXIL_STRB_BITS-1:0] wstrb;
    } axil_wr_t;

endpackage

`default_nettype wire
